//--- src.f
+incdir+.
regWindowPkg.sv
writeDecoder.sv
physRegFile.sv
windowView.sv
registerWindow.sv
registerWindow_assertions.sv
registerWindowTb.sv

//--- registerWindowTasks.svh
`ifndef REGISTER_WINDOW_TASKS_SVH
`define REGISTER_WINDOW_TASKS_SVH

	// Bounded by its count
	task automatic waitCycles(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(posedge clock);
		end
	endtask

	// Held over one rising edge, then the strobe drops
	task automatic driveRequest(input int window, input logic load,
		input logic [31:0] regSel, input regWindowPkg::dataT data);
		@(posedge clock);
		#0.5;
		cwp = regWindowPkg::cwpT'(window);
		writeReq.load = load;
		writeReq.regSel = regSel;
		writeReq.data = data;
		@(posedge clock);
		#0.5;
		writeReq.load = 1'b0;
		writeReq.regSel = '0;
	endtask

	task automatic writeReg(input int window, input int regNum, input regWindowPkg::dataT data);
		driveRequest(window, 1'b1, 32'd1 << regNum, data);
		storeModel(window, regNum, data);
	endtask

	task automatic checkWindow(input int window);
		regWindowPkg::dataT expected;
		@(posedge clock);
		#0.5;
		cwp = regWindowPkg::cwpT'(window);
		@(negedge clock); // Mid cycle, view settled
		checkCount++;
		assert (windowFault === 1'b0)
		else
		begin
			errorCount++;
			$display("[ERROR] %0t: windowFault set for valid window %0d", $time, window);
		end
		for (int r = 0; r < VisibleRegs; r++)
		begin
			expected = expectedReg(window, r);
			checkCount++;
			assert (visibleRegs[r] === expected)
			else
			begin
				errorCount++;
				$display("[ERROR] %0t: window %0d r%0d expected %h got %h",
					$time, window, r, expected, visibleRegs[r]);
			end
		end
	endtask

	task automatic checkAllWindows();
		for (int w = 0; w < NumWindows; w++)
		begin
			checkWindow(w);
		end
	endtask

	task automatic resetIsClear();
		checkAllWindows();
	endtask

	// Each global written from a different window
	task automatic globalsShared();
		for (int r = 0; r < GroupSize; r++)
		begin
			writeReg(r % NumWindows, r, randomWord());
		end
		checkAllWindows();
	endtask

	task automatic localsPrivate();
		for (int w = 0; w < NumWindows; w++)
		begin
			for (int r = 16; r < 24; r++)
			begin
				writeReg(w, r, randomWord());
			end
			checkAllWindows();
		end
	endtask

	task automatic outsOverlapIns();
		for (int w = 1; w < NumWindows; w++)
		begin
			for (int r = 8; r < 16; r++)
			begin
				writeReg(w, r, randomWord());
			end
			checkAllWindows();
		end
		// Top window ins have no partner
		for (int r = 24; r < 32; r++)
		begin
			writeReg(NumWindows - 1, r, randomWord());
		end
		checkAllWindows();
	endtask

	task automatic badRequestsIgnored();
		driveRequest(0, 1'b1, 32'd0, randomWord());
		driveRequest(1, 1'b1, (32'd1 << 17) | (32'd1 << 9), randomWord());
		driveRequest(2, 1'b1, 32'hffff_ffff, randomWord());
		driveRequest(3, 1'b0, 32'd1 << 20, randomWord()); // load low
		checkAllWindows();
	endtask

	task automatic faultBlocksAccess(input int badCwp);
		@(posedge clock);
		#0.5;
		cwp = regWindowPkg::cwpT'(badCwp);
		@(negedge clock);
		checkCount++;
		assert (windowFault === 1'b1)
		else
		begin
			errorCount++;
			$display("[ERROR] %0t: windowFault low for cwp %0d", $time, badCwp);
		end
		checkCount++;
		assert (visibleRegs === '0)
		else
		begin
			errorCount++;
			$display("[ERROR] %0t: view not zero for cwp %0d", $time, badCwp);
		end
		driveRequest(badCwp, 1'b1, 32'd1 << 3, randomWord());
		driveRequest(badCwp, 1'b1, 32'd1 << 18, randomWord());
		driveRequest(badCwp, 1'b1, 32'd1 << 27, randomWord());
		checkAllWindows();
	endtask

`endif

//--- registerWindowTb.sv
`timescale 1ns/10ps
`default_nettype none

module registerWindowTb;

	localparam int NumWindows = 4;
	localparam int GroupSize = regWindowPkg::GroupSize;
	localparam int VisibleRegs = regWindowPkg::VisibleRegs;

	logic clock;
	logic arstN;
	regWindowPkg::cwpT cwp;
	regWindowPkg::writeReqT writeReq;
	regWindowPkg::visibleRegsT visibleRegs;
	logic windowFault;

	int errorCount = 0;
	int checkCount = 0;
	int assertFails;

	logic [15:0] lfsrState = 16'd15;

	// Architectural model, ins of window w are outs of window w + 1
	regWindowPkg::dataT globalModel [GroupSize];
	regWindowPkg::dataT outModel [NumWindows][GroupSize];
	regWindowPkg::dataT localModel [NumWindows][GroupSize];
	regWindowPkg::dataT topInModel [GroupSize];

	registerWindow #(
		.DataWidth(regWindowPkg::DataWidth),
		.NumWindows(NumWindows)
	)
	i_registerWindow
	(
		.clock(clock),
		.arstN(arstN),
		.cwp(cwp),
		.writeReq(writeReq),
		.visibleRegs(visibleRegs),
		.windowFault(windowFault)
	);

	initial
	begin
		clock = 1'b0;
	end

	always #2 clock = ~clock;

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic lfsrBit();
		logic feedback;
		feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], feedback};
		return feedback;
	endfunction

	function automatic regWindowPkg::dataT randomWord();
		regWindowPkg::dataT word;
		for (int i = 0; i < regWindowPkg::DataWidth; i++)
		begin
			word[i] = lfsrBit();
		end
		return word;
	endfunction

	function automatic void clearModel();
		for (int i = 0; i < GroupSize; i++)
		begin
			globalModel[i] = '0;
			topInModel[i] = '0;
			for (int w = 0; w < NumWindows; w++)
			begin
				outModel[w][i] = '0;
				localModel[w][i] = '0;
			end
		end
	endfunction

	function automatic regWindowPkg::dataT expectedReg(input int window, input int regNum);
		int offset;
		offset = regNum % GroupSize;
		case (regNum / GroupSize)
			0: return globalModel[offset];
			1: return outModel[window][offset];
			2: return localModel[window][offset];
			default:
			begin
				if (window == NumWindows - 1)
				begin
					return topInModel[offset];
				end
				return outModel[window + 1][offset];
			end
		endcase
	endfunction

	function automatic void storeModel(input int window, input int regNum,
		input regWindowPkg::dataT data);
		int offset;
		offset = regNum % GroupSize;
		case (regNum / GroupSize)
			0: globalModel[offset] = data;
			1: outModel[window][offset] = data;
			2: localModel[window][offset] = data;
			default:
			begin
				if (window == NumWindows - 1)
				begin
					topInModel[offset] = data;
				end
				else
				begin
					outModel[window + 1][offset] = data;
				end
			end
		endcase
	endfunction

	initial
	begin
		arstN = 1'b0;
		cwp = '0;
		writeReq = '0;
		clearModel();
		waitCycles(10);
		#0.5;
		arstN = 1'b1;

		resetIsClear();
		globalsShared();
		localsPrivate();
		outsOverlapIns();
		badRequestsIgnored();
		faultBlocksAccess(4);
		faultBlocksAccess(7);
		faultBlocksAccess(31);

		waitCycles(2);
		assertFails = i_registerWindow.i_registerWindowAssertions.failCount;
		$display("Checks: %0d, check errors: %0d, assertion failures: %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	`include "registerWindowTasks.svh"

endmodule

`default_nettype wire

//--- registerWindow_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module registerWindowAssertions #(
	parameter int DataWidth = regWindowPkg::DataWidth,
	parameter int NumWindows = 4,
	localparam int PhysRegs = regWindowPkg::physRegCount(NumWindows)
)
(
	input wire logic clock,
	input wire logic arstN,
	input wire regWindowPkg::writeReqT writeReq,
	input wire logic physWrite,
	input wire logic windowFault,
	input wire logic [PhysRegs-1:0][DataWidth-1:0] physRegs,
	input wire regWindowPkg::visibleRegsT visibleRegs
);

	// Failures so far
	int failCount = 0;

	// Malformed select must never reach the storage
	noWriteOnBadSelect: assert property (@(posedge clock) disable iff (!arstN)
		($countones(writeReq.regSel) != 1) |-> !physWrite)
	else
	begin
		failCount++;
		$error("physWrite high with a regSel that is not one-hot");
	end

	// Storage untouched across an edge with a bad cwp
	noWriteOnFault: assert property (@(posedge clock) disable iff (!arstN)
		windowFault |=> $stable(physRegs))
	else
	begin
		failCount++;
		$error("physical registers changed while windowFault was set");
	end

	// First edge out of reset sees a cleared file
	clearAfterReset: assert property (@(posedge clock)
		$rose(arstN) |-> (visibleRegs == '0))
	else
	begin
		failCount++;
		$error("visibleRegs not zero after reset");
	end

endmodule

bind registerWindow registerWindowAssertions #(
	.DataWidth(DataWidth),
	.NumWindows(NumWindows)
)
i_registerWindowAssertions
(
	.clock(clock),
	.arstN(arstN),
	.writeReq(writeReq),
	.physWrite(physWrite),
	.windowFault(windowFault),
	.physRegs(physRegs),
	.visibleRegs(visibleRegs)
);

`default_nettype wire

//--- registerWindow.sv
`timescale 1ns/10ps
`default_nettype none

module registerWindow #(
	parameter int DataWidth = regWindowPkg::DataWidth,
	parameter int NumWindows = 4,
	localparam int PhysRegs = regWindowPkg::physRegCount(NumWindows),
	localparam int PhysIdxWidth = $clog2(PhysRegs)
)
(
	input wire logic clock,
	input wire logic arstN,
	input wire regWindowPkg::cwpT cwp,
	input wire regWindowPkg::writeReqT writeReq,
	output wire regWindowPkg::visibleRegsT visibleRegs,
	output wire logic windowFault
);

	// Translated write
	logic [PhysIdxWidth-1:0] physIndex;
	logic physWrite;

	// Flat storage, globals at the bottom
	logic [PhysRegs-1:0][DataWidth-1:0] physRegs;

	// Visible register select and cwp to physical index
	writeDecoder #(
		.NumWindows(NumWindows)
	)
	i_writeDecoder
	(
		.cwp(cwp),
		.writeReq(writeReq),
		.physIndex(physIndex),
		.physWrite(physWrite),
		.windowFault(windowFault)
	);

	physRegFile #(
		.DataWidth(DataWidth),
		.NumWindows(NumWindows)
	)
	i_physRegFile
	(
		.clock(clock),
		.arstN(arstN),
		.physIndex(physIndex),
		.physWrite(physWrite),
		.writeData(writeReq.data),
		.physRegs(physRegs)
	);

	// Read side follows cwp with no clock
	windowView #(
		.DataWidth(DataWidth),
		.NumWindows(NumWindows)
	)
	i_windowView
	(
		.cwp(cwp),
		.physRegs(physRegs),
		.visibleRegs(visibleRegs)
	);

endmodule

`default_nettype wire

//--- windowView.sv
`timescale 1ns/10ps
`default_nettype none

module windowView #(
	parameter int DataWidth = regWindowPkg::DataWidth,
	parameter int NumWindows = 4,
	localparam int PhysRegs = regWindowPkg::physRegCount(NumWindows)
)
(
	input wire regWindowPkg::cwpT cwp,
	input wire logic [PhysRegs-1:0][DataWidth-1:0] physRegs,
	output wire regWindowPkg::visibleRegsT visibleRegs
);

	localparam int GroupSize = regWindowPkg::GroupSize;

	logic inRange;
	int unsigned windowBase;

	assign inRange = (cwp < NumWindows);

	// Start of the current window's outs
	assign windowBase = GroupSize + 2 * GroupSize * int'(cwp);

	for (genvar v = 0; v < regWindowPkg::VisibleRegs; v++)
	begin : g_visible
		localparam regWindowPkg::regionT Region = regWindowPkg::regionT'(v / GroupSize);
		localparam int Offset = v % GroupSize;

		int unsigned physIdx;

		always_comb
		begin
			case (Region)
				regWindowPkg::Global:
				begin
					physIdx = Offset; // Shared by every window
				end
				regWindowPkg::Out:
				begin
					physIdx = windowBase + Offset;
				end
				regWindowPkg::Local:
				begin
					physIdx = windowBase + GroupSize + Offset;
				end
				default:
				begin
					// Ins overlap the next window's outs
					physIdx = windowBase + 2 * GroupSize + Offset;
				end
			endcase
		end

		assign visibleRegs[v] = inRange ? physRegs[physIdx] : '0; // Zero view on a bad cwp
	end

endmodule

`default_nettype wire

//--- physRegFile.sv
`timescale 1ns/10ps
`default_nettype none

module physRegFile #(
	parameter int DataWidth = regWindowPkg::DataWidth,
	parameter int NumWindows = 4,
	localparam int PhysRegs = regWindowPkg::physRegCount(NumWindows),
	localparam int PhysIdxWidth = $clog2(PhysRegs)
)
(
	input wire logic clock,
	input wire logic arstN,
	input wire logic [PhysIdxWidth-1:0] physIndex,
	input wire logic physWrite,
	input wire regWindowPkg::dataT writeData,
	output logic [PhysRegs-1:0][DataWidth-1:0] physRegs
);

	// One enable per physical register
	logic [PhysRegs-1:0] regWrite;

	always_comb
	begin
		regWrite = '0;
		if (physWrite)
		begin
			for (int r = 0; r < PhysRegs; r++)
			begin
				if (physIndex == PhysIdxWidth'(r))
				begin
					regWrite[r] = 1'b1;
				end
			end
		end
	end

	// Single write port, whole file cleared on reset
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			physRegs <= '0;
		end
		else
		begin
			for (int r = 0; r < PhysRegs; r++)
			begin
				if (regWrite[r])
				begin
					physRegs[r] <= writeData;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- writeDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module writeDecoder #(
	parameter int NumWindows = 4,
	localparam int PhysIdxWidth = $clog2(regWindowPkg::physRegCount(NumWindows))
)
(
	input wire regWindowPkg::cwpT cwp,
	input wire regWindowPkg::writeReqT writeReq,
	output logic [PhysIdxWidth-1:0] physIndex,
	output logic physWrite,
	output logic windowFault
);

	localparam int GroupSize = regWindowPkg::GroupSize;
	localparam int RegNumWidth = regWindowPkg::RegNumWidth;
	localparam int OffsetWidth = regWindowPkg::OffsetWidth;
	localparam int CountWidth = $clog2(regWindowPkg::VisibleRegs + 1);

	logic [RegNumWidth-1:0] selNum;
	logic [CountWidth-1:0] selCount;
	logic oneHot;

	regWindowPkg::regionT region;
	logic [OffsetWidth-1:0] offset;
	int unsigned window;
	int unsigned base;

	// Encode the select and count its set bits
	always_comb
	begin
		selNum = '0;
		selCount = '0;
		for (int i = 0; i < regWindowPkg::VisibleRegs; i++)
		begin
			if (writeReq.regSel[i])
			begin
				selNum = RegNumWidth'(i);
				selCount = selCount + 1'b1;
			end
		end
	end

	assign oneHot = (selCount == CountWidth'(1));

	assign region = regWindowPkg::regionT'(selNum[RegNumWidth-1:OffsetWidth]);
	assign offset = selNum[OffsetWidth-1:0];

	assign windowFault = (cwp >= NumWindows);
	assign window = int'(cwp);

	// Each window advances two groups
	always_comb
	begin
		case (region)
			regWindowPkg::Global:
			begin
				base = 0;
			end
			regWindowPkg::Out:
			begin
				base = GroupSize + 2 * GroupSize * window;
			end
			regWindowPkg::Local:
			begin
				base = 2 * GroupSize + 2 * GroupSize * window;
			end
			default:
			begin
				base = 3 * GroupSize + 2 * GroupSize * window; // Outs of window + 1
			end
		endcase
	end

	assign physIndex = windowFault ? '0 : PhysIdxWidth'(base + offset);

	// No write on a bad window or a malformed select
	assign physWrite = writeReq.load & oneHot & ~windowFault;

endmodule

`default_nettype wire

//--- regWindowPkg.sv
`default_nettype none

package regWindowPkg;

	// Register word width
	parameter int DataWidth = 32;

	// Architectural view: globals, outs, locals, ins
	parameter int VisibleRegs = 32;
	parameter int GroupSize = 8;

	parameter int CwpWidth = 5;
	parameter int RegNumWidth = $clog2(VisibleRegs);
	parameter int OffsetWidth = $clog2(GroupSize);

	typedef logic [DataWidth-1:0] dataT;

	typedef logic [CwpWidth-1:0] cwpT;

	// Encoded to match the upper two bits of the register number
	typedef enum logic [1:0]
	{
		Global = 2'd0,
		Out = 2'd1,
		Local = 2'd2,
		In = 2'd3
	} regionT;

	typedef struct packed
	{
		logic load; // Load strobe
		logic [VisibleRegs-1:0] regSel; // One-hot register enable
		dataT data;
	} writeReqT;

	// Indexed by architectural register number
	typedef dataT [VisibleRegs-1:0] visibleRegsT;

	// Globals, two groups per window, and the ins of the top window
	function automatic int physRegCount(input int numWindows);
		int count;
		count = GroupSize;
		count = count + 2 * GroupSize * numWindows;
		count = count + GroupSize;
		return count;
	endfunction

endpackage

`default_nettype wire
